// ==== include/eth_rx_settings.svh ====
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

// Station address accepted by the receiver
`define ETH_BOARD_MAC 48'h309C231EEC21

// Preamble and start frame delimiter octets
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE 8'hD5

// Preamble bytes before the delimiter
`define ETH_PREAMBLE_LEN 7

// Bytes per MAC address field
`define ETH_MAC_LEN 6

`endif

// ==== src/eth_rx_pkg.sv ====
package eth_rx_pkg;

    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;

    // Bytes left in the current header field
    typedef logic [3:0]  field_count_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DEST_MAC,
        SRC_MAC,
        PAYLOAD,
        FINISH
    } rx_state_t;

    // Assembled octet with the delayed frame level
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  in_frame;
    } rx_byte_t;

    // Strobes from the FSM, already qualified by the byte strobe
    typedef struct packed {
        logic dest_shift;
        logic src_shift;
        logic payload_shift;
        logic frame_end;
    } capture_ctrl_t;

endpackage

// ==== src/eth_nibble_assembler.sv ====
`timescale 1ns/1ps

module eth_nibble_assembler (
    input  logic                 phy_rx_clk,
    input  logic                 reset,
    input  eth_rx_pkg::nibble_t  phy_rxd,
    input  logic                 phy_rx_ctrl,
    output eth_rx_pkg::rx_byte_t rx_byte
);

    // High while the low nibble of a byte is held
    logic                phase;
    logic                byte_valid;
    logic                in_frame_q;
    eth_rx_pkg::nibble_t low_nibble;
    eth_rx_pkg::byte_t   byte_data;

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            phase      <= 1'b0;
            byte_valid <= 1'b0;
            in_frame_q <= 1'b0;
        end
        else
        begin
            phase      <= phy_rx_ctrl ? ~phase : 1'b0;
            byte_valid <= phy_rx_ctrl & phase;
            in_frame_q <= phy_rx_ctrl;
        end
    end

    // Low nibble arrives first
    always_ff @(posedge phy_rx_clk)
    begin
        if (phy_rx_ctrl && !phase)
            low_nibble <= phy_rxd;
        if (phy_rx_ctrl && phase)
            byte_data <= {phy_rxd, low_nibble};
    end

    assign rx_byte = '{valid: byte_valid, data: byte_data, in_frame: in_frame_q};

    ///////////////////////////////
    // Byte strobe spacing
    a_valid_single: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        rx_byte.valid |=> !rx_byte.valid
    ) else $error("Byte strobe held for two cycles");

endmodule

// ==== src/eth_field_counter.sv ====
`timescale 1ns/1ps

module eth_field_counter (
    input  logic                     phy_rx_clk,
    input  logic                     reset,
    input  logic                     cnt_load,
    input  eth_rx_pkg::field_count_t cnt_value,
    input  logic                     cnt_dec,
    output logic                     cnt_last
);

    eth_rx_pkg::field_count_t count;

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (cnt_load)
        begin
            count <= cnt_value;
        end
        else if (cnt_dec)
        begin
            count <= count - 1'b1;
        end
    end

    // One byte left means the current byte closes the field
    assign cnt_last = (count == eth_rx_pkg::field_count_t'(1));

    ///////////////////////////////
    // Control from the FSM
    a_load_dec_excl: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        !(cnt_load && cnt_dec)
    ) else $error("Field counter loaded and decremented together");

    a_no_underflow: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        cnt_dec |-> (count != '0)
    ) else $error("Field counter decremented past zero");

endmodule

// ==== src/eth_rx_fsm.sv ====
`timescale 1ns/1ps
`include "eth_rx_settings.svh"

module eth_rx_fsm (
    input  logic                      phy_rx_clk,
    input  logic                      reset,
    input  eth_rx_pkg::rx_byte_t      rx_byte,
    input  logic                      cnt_last,
    output logic                      cnt_load,
    output eth_rx_pkg::field_count_t  cnt_value,
    output logic                      cnt_dec,
    output eth_rx_pkg::capture_ctrl_t capture
);

    eth_rx_pkg::rx_state_t state;
    eth_rx_pkg::rx_state_t state_next;

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
            state <= eth_rx_pkg::IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        cnt_load   = 1'b0;
        cnt_dec    = 1'b0;
        case (state)
            eth_rx_pkg::IDLE:
            begin
                if (rx_byte.valid && rx_byte.data == `ETH_PREAMBLE_BYTE)
                begin
                    state_next = eth_rx_pkg::PREAMBLE;
                    cnt_load   = 1'b1;
                end
            end
            eth_rx_pkg::PREAMBLE:
            begin
                if (!rx_byte.in_frame)
                    state_next = eth_rx_pkg::IDLE;
                else if (rx_byte.valid)
                begin
                    if (rx_byte.data != `ETH_PREAMBLE_BYTE)
                        state_next = eth_rx_pkg::IDLE;
                    else
                    begin
                        cnt_dec = 1'b1;
                        if (cnt_last)
                            state_next = eth_rx_pkg::SFD;
                    end
                end
            end
            eth_rx_pkg::SFD:
            begin
                if (!rx_byte.in_frame)
                    state_next = eth_rx_pkg::IDLE;
                else if (rx_byte.valid)
                begin
                    // An eighth 0x55 also lands here and aborts
                    if (rx_byte.data == `ETH_SFD_BYTE)
                    begin
                        state_next = eth_rx_pkg::DEST_MAC;
                        cnt_load   = 1'b1;
                    end
                    else
                        state_next = eth_rx_pkg::IDLE;
                end
            end
            eth_rx_pkg::DEST_MAC:
            begin
                if (!rx_byte.in_frame)
                    state_next = eth_rx_pkg::IDLE;
                else if (rx_byte.valid)
                begin
                    if (cnt_last)
                    begin
                        state_next = eth_rx_pkg::SRC_MAC;
                        cnt_load   = 1'b1;
                    end
                    else
                        cnt_dec = 1'b1;
                end
            end
            eth_rx_pkg::SRC_MAC:
            begin
                if (!rx_byte.in_frame)
                    state_next = eth_rx_pkg::IDLE;
                else if (rx_byte.valid)
                begin
                    cnt_dec = 1'b1;
                    if (cnt_last)
                        state_next = eth_rx_pkg::PAYLOAD;
                end
            end
            eth_rx_pkg::PAYLOAD:
            begin
                if (!rx_byte.in_frame)
                    state_next = eth_rx_pkg::FINISH;
            end
            eth_rx_pkg::FINISH:
                state_next = eth_rx_pkg::IDLE;
            default:
                state_next = eth_rx_pkg::IDLE;
        endcase
    end

    // Preamble loads one less, the first byte was already seen
    assign cnt_value = (state == eth_rx_pkg::IDLE) ?
                       eth_rx_pkg::field_count_t'(`ETH_PREAMBLE_LEN - 1) :
                       eth_rx_pkg::field_count_t'(`ETH_MAC_LEN);

    assign capture = '{
        dest_shift:    (state == eth_rx_pkg::DEST_MAC) && rx_byte.valid,
        src_shift:     (state == eth_rx_pkg::SRC_MAC) && rx_byte.valid,
        payload_shift: (state == eth_rx_pkg::PAYLOAD) && rx_byte.valid,
        frame_end:     (state == eth_rx_pkg::PAYLOAD) && !rx_byte.in_frame
    };

    ///////////////////////////////
    a_state_legal: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        state inside {eth_rx_pkg::IDLE, eth_rx_pkg::PREAMBLE, eth_rx_pkg::SFD,
                      eth_rx_pkg::DEST_MAC, eth_rx_pkg::SRC_MAC,
                      eth_rx_pkg::PAYLOAD, eth_rx_pkg::FINISH}
    ) else $error("FSM in illegal state %0d", state);

endmodule

// ==== src/eth_mac_capture.sv ====
`timescale 1ns/1ps
`include "eth_rx_settings.svh"

module eth_mac_capture (
    input  logic                      phy_rx_clk,
    input  logic                      reset,
    input  eth_rx_pkg::rx_byte_t      rx_byte,
    input  eth_rx_pkg::capture_ctrl_t capture,
    output logic                      mac_match,
    output eth_rx_pkg::mac_addr_t     src_mac
);

    eth_rx_pkg::mac_addr_t dest_mac;

    // First byte on the wire ends up in the top octet
    always_ff @(posedge phy_rx_clk)
    begin
        if (capture.dest_shift)
            dest_mac <= {dest_mac[39:0], rx_byte.data};
        if (capture.src_shift)
            src_mac <= {src_mac[39:0], rx_byte.data};
    end

    // Destination is complete once the source field starts
    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            mac_match <= 1'b0;
        end
        else if (capture.frame_end || capture.dest_shift)
        begin
            mac_match <= 1'b0;
        end
        else if (capture.src_shift)
        begin
            mac_match <= (dest_mac == `ETH_BOARD_MAC);
        end
    end

    ///////////////////////////////
    // Source address held through the payload
    a_src_stable: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        capture.payload_shift |=> $stable(src_mac)
    ) else $error("Source address changed during payload");

endmodule

// ==== src/eth_payload_out.sv ====
`timescale 1ns/1ps

module eth_payload_out (
    input  logic                      phy_rx_clk,
    input  logic                      reset,
    input  eth_rx_pkg::rx_byte_t      rx_byte,
    input  eth_rx_pkg::capture_ctrl_t capture,
    input  logic                      mac_match,
    output eth_rx_pkg::byte_t         rx_data,
    output logic                      rx_data_valid,
    output logic                      frame_done
);

    logic take_byte;

    assign take_byte = capture.payload_shift & mac_match;

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            rx_data_valid <= 1'b0;
            frame_done    <= 1'b0;
        end
        else
        begin
            rx_data_valid <= take_byte;
            frame_done    <= capture.frame_end & mac_match;
        end
    end

    always_ff @(posedge phy_rx_clk)
    begin
        if (take_byte)
            rx_data <= rx_byte.data;
    end

    ///////////////////////////////
    // Output strobes never run back to back
    a_data_gap: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        rx_data_valid |=> !rx_data_valid
    ) else $error("rx_data_valid high on two cycles");

    a_done_alone: assert property (
        @(posedge phy_rx_clk) disable iff (reset)
        frame_done |-> !rx_data_valid
    ) else $error("frame_done together with a payload byte");

endmodule

// ==== src/eth_frame_receiver.sv ====
`timescale 1ns/1ps

module eth_frame_receiver (
    input  logic                  phy_rx_clk,
    input  logic                  reset,
    input  eth_rx_pkg::nibble_t   phy_rxd,
    input  logic                  phy_rx_ctrl,
    output eth_rx_pkg::byte_t     rx_data,
    output logic                  rx_data_valid,
    output logic                  frame_done,
    output eth_rx_pkg::mac_addr_t src_mac
);

    eth_rx_pkg::rx_byte_t      rx_byte;
    eth_rx_pkg::capture_ctrl_t capture;
    eth_rx_pkg::field_count_t  cnt_value;
    logic                      cnt_load;
    logic                      cnt_dec;
    logic                      cnt_last;
    logic                      mac_match;

    ///////////////////////////////
    // Byte path
    eth_nibble_assembler u_assembler (
        .phy_rx_clk  (phy_rx_clk),
        .reset       (reset),
        .phy_rxd     (phy_rxd),
        .phy_rx_ctrl (phy_rx_ctrl),
        .rx_byte     (rx_byte)
    );

    ///////////////////////////////
    // Frame control
    eth_rx_fsm u_fsm (
        .phy_rx_clk (phy_rx_clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .cnt_last   (cnt_last),
        .cnt_load   (cnt_load),
        .cnt_value  (cnt_value),
        .cnt_dec    (cnt_dec),
        .capture    (capture)
    );

    eth_field_counter u_counter (
        .phy_rx_clk (phy_rx_clk),
        .reset      (reset),
        .cnt_load   (cnt_load),
        .cnt_value  (cnt_value),
        .cnt_dec    (cnt_dec),
        .cnt_last   (cnt_last)
    );

    ///////////////////////////////
    // Address check and payload
    eth_mac_capture u_mac_capture (
        .phy_rx_clk (phy_rx_clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .capture    (capture),
        .mac_match  (mac_match),
        .src_mac    (src_mac)
    );

    eth_payload_out u_payload_out (
        .phy_rx_clk    (phy_rx_clk),
        .reset         (reset),
        .rx_byte       (rx_byte),
        .capture       (capture),
        .mac_match     (mac_match),
        .rx_data       (rx_data),
        .rx_data_valid (rx_data_valid),
        .frame_done    (frame_done)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset spans eight rising edges
    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== verification/tb_eth_frame_receiver.sv ====
`timescale 1ns/1ps
`include "eth_rx_settings.svh"

module tb_eth_frame_receiver;

    localparam int GAP_CYCLES   = 12;
    localparam int DONE_TIMEOUT = 200;
    localparam int RESET_LIMIT  = 50;

    logic                  phy_rx_clk;
    logic                  reset;
    eth_rx_pkg::nibble_t   phy_rxd;
    logic                  phy_rx_ctrl;
    eth_rx_pkg::byte_t     rx_data;
    logic                  rx_data_valid;
    logic                  frame_done;
    eth_rx_pkg::mac_addr_t src_mac;

    // Predicted payload stream of accepted frames
    eth_rx_pkg::byte_t     exp_q[$];
    eth_rx_pkg::byte_t     exp_head;
    int                    exp_count;
    eth_rx_pkg::mac_addr_t exp_src;
    int                    frames_expected = 0;
    int                    bytes_expected = 0;
    int                    done_count = 0;
    int                    bytes_seen = 0;
    logic                  quiet_expected;
    int                    seed;
    eth_rx_pkg::byte_t     payload[$];

    tb_clock_gen clock_gen (
        .clk   (phy_rx_clk),
        .reset (reset)
    );

    eth_frame_receiver UUT (
        .phy_rx_clk    (phy_rx_clk),
        .reset         (reset),
        .phy_rxd       (phy_rxd),
        .phy_rx_ctrl   (phy_rx_ctrl),
        .rx_data       (rx_data),
        .rx_data_valid (rx_data_valid),
        .frame_done    (frame_done),
        .src_mac       (src_mac)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic void refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_q.size() != 0) ? exp_q[0] : 8'h00;
    endfunction

    task automatic drive_nibble(input eth_rx_pkg::nibble_t n, input logic ctrl);
        @(posedge phy_rx_clk);
        phy_rxd     <= n;
        phy_rx_ctrl <= ctrl;
    endtask

    // abort_at counts whole bytes sent before phy_rx_ctrl falls, -1 for none
    task automatic send_frame(
        input int                    pre_len,
        input eth_rx_pkg::byte_t     sfd,
        input eth_rx_pkg::mac_addr_t dest,
        input eth_rx_pkg::mac_addr_t src,
        input eth_rx_pkg::byte_t     pl[$],
        input int                    abort_at
    );
        eth_rx_pkg::byte_t wire_bytes[$];
        int                i;
        int                sent;
        logic              accepted;
        for (i = 0; i < pre_len; i++)
            wire_bytes.push_back(`ETH_PREAMBLE_BYTE);
        wire_bytes.push_back(sfd);
        for (i = `ETH_MAC_LEN - 1; i >= 0; i--)
            wire_bytes.push_back(dest[8*i +: 8]);
        for (i = `ETH_MAC_LEN - 1; i >= 0; i--)
            wire_bytes.push_back(src[8*i +: 8]);
        for (i = 0; i < pl.size(); i++)
            wire_bytes.push_back(pl[i]);
        // Only a clean header to the board address reaches the outputs
        accepted = (pre_len == `ETH_PREAMBLE_LEN) && (sfd == `ETH_SFD_BYTE) &&
                   (dest == `ETH_BOARD_MAC) && (abort_at < 0);
        if (accepted)
        begin
            for (i = 0; i < pl.size(); i++)
                exp_q.push_back(pl[i]);
            bytes_expected  += pl.size();
            frames_expected += 1;
            exp_src          = src;
            refresh_head();
        end
        sent = (abort_at < 0) ? wire_bytes.size() : abort_at;
        for (i = 0; i < sent; i++)
        begin
            drive_nibble(wire_bytes[i][3:0], 1'b1);
            drive_nibble(wire_bytes[i][7:4], 1'b1);
        end
        for (i = 0; i < GAP_CYCLES; i++)
            drive_nibble(4'h0, 1'b0);
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done_count != frames_expected && cycles < DONE_TIMEOUT)
        begin
            @(posedge phy_rx_clk);
            cycles++;
        end
        if (done_count != frames_expected)
            stop_with_failure("Timed out waiting for frame_done");
    endtask

    // Bytes A0 upward, never a preamble octet
    task automatic make_fixed_payload(input int len);
        int i;
        payload.delete();
        for (i = 0; i < len; i++)
            payload.push_back(eth_rx_pkg::byte_t'(8'hA0 + i));
    endtask

    task automatic make_random_payload();
        int len;
        int i;
        payload.delete();
        len = 1 + ($unsigned($random(seed)) % 20);
        for (i = 0; i < len; i++)
            payload.push_back(eth_rx_pkg::byte_t'($random(seed)));
    endtask

    function automatic eth_rx_pkg::mac_addr_t random_other_mac();
        eth_rx_pkg::mac_addr_t mac;
        mac = {16'($random(seed)), 32'($random(seed))};
        if (mac == `ETH_BOARD_MAC)
            mac[0] = ~mac[0];
        return mac;
    endfunction

    // Consume delivered bytes and count frame ends
    always @(posedge phy_rx_clk)
    begin
        if (!reset && rx_data_valid && exp_q.size() != 0)
        begin
            void'(exp_q.pop_front());
            bytes_seen <= bytes_seen + 1;
            refresh_head();
        end
        if (!reset && frame_done)
            done_count <= done_count + 1;
    end

    //////////////////////////////
    // Output checks, sampled mid-cycle
    a_quiet_after_reset: assert property (
        @(negedge phy_rx_clk) disable iff (reset)
        quiet_expected |-> (!rx_data_valid && !frame_done)
    ) else stop_with_failure("Output strobe while the PHY was idle after reset");

    a_data_expected: assert property (
        @(negedge phy_rx_clk) disable iff (reset)
        rx_data_valid |-> (exp_count != 0)
    ) else stop_with_failure("rx_data_valid with no payload byte expected");

    a_data_value: assert property (
        @(negedge phy_rx_clk) disable iff (reset)
        (rx_data_valid && exp_count != 0) |-> (rx_data == exp_head)
    ) else stop_with_failure($sformatf("Mismatch rx_data: got 0x%h, expected 0x%h",
                                       rx_data, exp_head));

    a_done_expected: assert property (
        @(negedge phy_rx_clk) disable iff (reset)
        frame_done |-> (done_count < frames_expected)
    ) else stop_with_failure("frame_done without an accepted frame");

    a_done_complete: assert property (
        @(negedge phy_rx_clk) disable iff (reset)
        frame_done |-> (exp_count == 0)
    ) else stop_with_failure("frame_done before the last payload byte");

    a_src_value: assert property (
        @(negedge phy_rx_clk) disable iff (reset)
        frame_done |-> (src_mac == exp_src)
    ) else stop_with_failure($sformatf("Mismatch src_mac: got 0x%h, expected 0x%h",
                                       src_mac, exp_src));

    initial
    begin
        int                    i;
        eth_rx_pkg::mac_addr_t dest;
        phy_rxd        = '0;
        phy_rx_ctrl    = 1'b0;
        quiet_expected = 1'b0;
        exp_src        = '0;
        seed           = 32'h7194;
        refresh_head();

        i = 0;
        while (reset && i < RESET_LIMIT)
        begin
            @(posedge phy_rx_clk);
            i++;
        end
        if (reset)
            stop_with_failure("Reset was never released");

        // Idle PHY right after reset
        quiet_expected = 1'b1;
        for (i = 0; i < 20; i++)
            @(posedge phy_rx_clk);
        quiet_expected = 1'b0;

        //////////////////////////////
        // Directed frames
        make_fixed_payload(12);
        send_frame(7, `ETH_SFD_BYTE, `ETH_BOARD_MAC, 48'h0A1B2C3D4E5F, payload, -1);
        wait_for_done();
        send_frame(7, `ETH_SFD_BYTE, 48'h309C231EEC20, 48'h112233445566, payload, -1);
        send_frame(6, `ETH_SFD_BYTE, `ETH_BOARD_MAC, 48'h112233445566, payload, -1);
        send_frame(7, 8'hD4, `ETH_BOARD_MAC, 48'h112233445566, payload, -1);

        // Aborts inside the destination and the source field
        send_frame(7, `ETH_SFD_BYTE, `ETH_BOARD_MAC, 48'hAABBCCDDEEF0, payload, 10);
        send_frame(7, `ETH_SFD_BYTE, `ETH_BOARD_MAC, 48'hAABBCCDDEEF0, payload, 17);
        make_fixed_payload(5);
        send_frame(7, `ETH_SFD_BYTE, `ETH_BOARD_MAC, 48'h6789ABCDEF01, payload, -1);
        wait_for_done();

        //////////////////////////////
        // Random frames
        for (i = 0; i < 30; i++)
        begin
            make_random_payload();
            if (($random(seed) & 32'h1) != 0)
                dest = `ETH_BOARD_MAC;
            else
                dest = random_other_mac();
            send_frame(7, `ETH_SFD_BYTE, dest, random_other_mac(), payload, -1);
            wait_for_done();
        end

        if (exp_q.size() == 0 && done_count == frames_expected &&
            bytes_seen == bytes_expected)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
            stop_with_failure($sformatf(
                "Mismatch totals: frames 0x%h of 0x%h, bytes 0x%h of 0x%h",
                done_count, frames_expected, bytes_seen, bytes_expected));
    end

endmodule

// ==== tb.f ====
+incdir+include
src/eth_rx_pkg.sv
src/eth_nibble_assembler.sv
src/eth_field_counter.sv
src/eth_rx_fsm.sv
src/eth_mac_capture.sv
src/eth_payload_out.sv
src/eth_frame_receiver.sv
verification/tb_clock_gen.sv
verification/tb_eth_frame_receiver.sv

// ==== Makefile ====
TOP := tb_eth_frame_receiver

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
